/* hw/bt_pkg.sv */
package bt_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  // one serial data byte, 8N1 payload
  typedef logic [7:0] byte_t;

  // one level per fan button
  typedef logic [4:0] btn_t;

  ////////////////////////////////////////////////////////////////////////////
  // uart state machines
  ////////////////////////////////////////////////////////////////////////////

  // receiver states
  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_cleanup
  } rx_state_t;

  // transmitter states
  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_cleanup
  } tx_state_t;

  // ascii '0' clears every button
  localparam byte_t cmd_clear_all = 8'd48;
  // ascii '1' is button 0, '2' button 1 and so on
  localparam byte_t cmd_first_btn = 8'd49;

  // 125 MHz / 9600 baud
  localparam int default_clks_per_bit = 13021;

endpackage

/* hw/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = bt_pkg::default_clks_per_bit
) (
  input  logic          clk,
  input  logic          reset_p,
  input  logic          rx,
  output bt_pkg::byte_t rx_byte,
  output logic          rx_valid
);

  import bt_pkg::*;

  // bit-period counter sized from the baud divider
  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'((clks_per_bit - 1) / 2);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

  rx_state_t        state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  byte_t            rx_shift;

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // two flops, line idles high
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      state    <= rx_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      case (state)
        rx_idle: begin
          rx_valid <= 1'b0;
          clk_cnt  <= '0;
          bit_idx  <= '0;
          // falling edge may be a start bit
          if (!rx_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // recheck the line half a bit later
          if (clk_cnt == half_cnt) begin
            clk_cnt <= '0;
            // still low, real start bit
            if (!rx_sync) begin
              state <= rx_data;
            end else begin
              // glitch, drop it
              state <= rx_idle;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            // mid-bit sample, lsb arrives first
            rx_shift <= {rx_sync, rx_shift[7:1]};
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_stop: begin
          // middle of stop bit, level not checked
          if (clk_cnt == last_cnt) begin
            clk_cnt  <= '0;
            rx_byte  <= rx_shift;
            rx_valid <= 1'b1;
            state    <= rx_cleanup;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_cleanup: begin
          // strobe is one cycle only
          rx_valid <= 1'b0;
          state    <= rx_idle;
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = bt_pkg::default_clks_per_bit
) (
  input  logic          clk,
  input  logic          reset_p,
  input  logic          tx_start,
  input  bt_pkg::byte_t tx_byte,
  output logic          tx,
  output logic          tx_busy
);

  import bt_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

  tx_state_t        state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  // byte held for the whole frame
  byte_t            data_hold;

  ////////////////////////////////////////////////////////////////////////////
  // 8N1 frame state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      state   <= tx_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      tx_busy <= 1'b0;
    end else begin
      case (state)
        tx_idle: begin
          tx      <= 1'b1;
          clk_cnt <= '0;
          bit_idx <= '0;
          // accept only here, a start while busy is lost
          if (tx_start) begin
            data_hold <= tx_byte;
            tx_busy   <= 1'b1;
            // start bit begins with busy
            tx        <= 1'b0;
            state     <= bt_pkg::tx_start;
          end
        end
        bt_pkg::tx_start: begin
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            tx      <= data_hold[0];
            state   <= tx_data;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        tx_data: begin
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              // stop bit
              tx    <= 1'b1;
              state <= tx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= data_hold[bit_idx + 3'd1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            tx_busy <= 1'b0;
            state   <= tx_cleanup;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        tx_cleanup: begin
          // one idle-high cycle before next accept
          state <= tx_idle;
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

endmodule

/* hw/btn_cmd_decoder.sv */
`timescale 1ns/1ps

module btn_cmd_decoder (
  input  logic          clk,
  input  logic          reset_p,
  input  bt_pkg::byte_t rx_byte,
  input  logic          rx_valid,
  output bt_pkg::btn_t  btn_levels
);

  import bt_pkg::*;

  // number of buttons and index width
  localparam int btn_n = $bits(btn_t);
  localparam int idx_w = $clog2(btn_n);

  byte_t            btn_offset;
  logic [idx_w-1:0] btn_idx;
  logic             is_btn_cmd;
  btn_t             btn_next;

  ////////////////////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////////////////////

  // distance from '1', wraps high below '1'
  assign btn_offset = rx_byte - cmd_first_btn;
  assign btn_idx    = btn_offset[idx_w-1:0];
  assign is_btn_cmd = (btn_offset < byte_t'(btn_n));

  always_comb begin
    // sticky by default
    btn_next = btn_levels;
    if (rx_byte == cmd_clear_all) begin
      btn_next = '0;
    end else if (is_btn_cmd) begin
      // set one, keep the others
      btn_next[btn_idx] = 1'b1;
    end else begin
      // unknown byte clears everything
      btn_next = '0;
    end
  end

  // levels move only on the rx strobe
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      btn_levels <= '0;
    end else if (rx_valid) begin
      btn_levels <= btn_next;
    end
  end

endmodule

/* hw/fan_bluetooth_top.sv */
`timescale 1ns/1ps

module fan_bluetooth_top #(
  parameter int clks_per_bit = bt_pkg::default_clks_per_bit
) (
  input  logic         clk,
  input  logic         reset_p,
  input  logic         rx,
  output logic         tx,
  output bt_pkg::btn_t btn_levels
);

  import bt_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  // echo path busy, strobes during it are dropped
  logic  tx_busy;

  ////////////////////////////////////////////////////////////////////////////
  // receive, decode, echo
  ////////////////////////////////////////////////////////////////////////////

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) uart_rx_inst (
    .clk      (clk),
    .reset_p  (reset_p),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  btn_cmd_decoder btn_cmd_decoder_inst (
    .clk        (clk),
    .reset_p    (reset_p),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .btn_levels (btn_levels)
  );

  // every received byte goes straight back out
  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) uart_tx_inst (
    .clk      (clk),
    .reset_p  (reset_p),
    .tx_start (rx_valid),
    .tx_byte  (rx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

endmodule

/* tb/tb_fan_bluetooth.sv */
`timescale 1ns/1ps

module tb_fan_bluetooth;

  import bt_pkg::*;

  localparam int clks_per_bit = 16;
  // longest quiet stretch on tx before the monitor complains
  localparam int idle_limit = 100 * clks_per_bit;

  logic  clk;
  logic  reset_p;
  logic  rx;
  logic  tx;
  btn_t  btn_levels;

  int    check_errors;
  int    other_errors;
  int    seed;
  bit    tb_done;
  byte_t echo_seen[$];
  byte_t echo_expected[$];
  // level check held back until the next frame is under way
  bit    pend_valid;
  byte_t pend_levels;
  string pend_name;

  fan_bluetooth_top #(
    .clks_per_bit (clks_per_bit)
  ) fan_bluetooth_top_inst (
    .clk        (clk),
    .reset_p    (reset_p),
    .rx         (rx),
    .tx         (tx),
    .btn_levels (btn_levels)
  );

  // 50 MHz
  always #10 clk = ~clk;

  task automatic compare_value(input string name, input byte_t expected, input byte_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // serial driver
  ////////////////////////////////////////////////////////////////////////////

  // called 2 ns after a rising edge, returns at the same phase
  task automatic drive_bit(input logic level);
    rx = level;
    repeat (clks_per_bit) @(posedge clk);
    #2;
  endtask

  task automatic idle_bits(input int n);
    rx = 1'b1;
    repeat (n * clks_per_bit) @(posedge clk);
    #2;
  endtask

  // 8N1, lsb first
  task automatic send_frame(input byte_t data);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
      // two bit periods past the end of a back-to-back predecessor
      if (i == 0 && pend_valid) begin
        compare_value(pend_name, pend_levels, byte_t'(btn_levels));
        pend_valid = 1'b0;
      end
    end
    drive_bit(1'b1);
  endtask

  // quarter bit low, then high for the rest of the bit
  task automatic send_glitch();
    rx = 1'b0;
    repeat (clks_per_bit / 4) @(posedge clk);
    #2;
    rx = 1'b1;
    repeat (clks_per_bit - clks_per_bit / 4) @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tx monitor, samples on falling edges
  ////////////////////////////////////////////////////////////////////////////

  initial begin : tx_monitor
    byte_t data;
    int    idle;
    for (idle = 0; reset_p !== 1'b0 && idle < 100; idle++) begin
      @(negedge clk);
    end
    idle = 0;
    while (!tb_done) begin
      @(negedge clk);
      if (tx === 1'b0) begin
        idle = 0;
        // middle of the start bit
        repeat (clks_per_bit / 2 - 1) @(negedge clk);
        if (tx !== 1'b0) begin
          $display("start bit on tx ended before its middle");
          other_errors++;
        end
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          data[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (tx !== 1'b1) begin
          $display("stop bit on tx was low");
          other_errors++;
        end
        echo_seen.push_back(data);
      end else begin
        idle++;
        if (idle == idle_limit) begin
          $display("no start bit seen on tx for %0d cycles", idle_limit);
          other_errors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // trace playback
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_trace
    int    fd;
    int    n;
    int    lineno;
    int    extra;
    int    echo;
    int    wait_cnt;
    bit    quiet;
    string line;
    string act;
    string name;
    byte_t data;
    byte_t exp_lv;
    clk = 1'b0;
    reset_p = 1'b1;
    rx = 1'b1;
    seed = 13226;
    repeat (16) @(posedge clk);
    #2;
    reset_p = 1'b0;
    // quiet line after reset
    compare_value("levels after reset", 8'h00, byte_t'(btn_levels));
    quiet = 1'b1;
    for (n = 0; n < 20 * clks_per_bit; n++) begin
      @(posedge clk);
      #2;
      if (tx !== 1'b1) begin
        quiet = 1'b0;
      end
    end
    compare_value("tx idle after reset", 8'h01, byte_t'(quiet));
    fd = $fopen("tb/cmd_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/cmd_trace.txt");
      other_errors++;
    end else begin
      lineno = 0;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        lineno++;
        if (n == 0 || line[0] == "#") begin
          continue;
        end
        if ($sscanf(line, "%s %h %h %d", act, data, exp_lv, echo) != 4) begin
          continue;
        end
        name = $sformatf("line %0d %s %02h", lineno, act, data);
        if (act == "glitch") begin
          send_glitch();
        end else if (act == "send" || act == "burst") begin
          if (echo != 0) begin
            echo_expected.push_back(data);
          end
          send_frame(data);
        end else begin
          $display("unknown action on trace line %0d", lineno);
          other_errors++;
          continue;
        end
        if (act == "burst") begin
          // next frame starts right away
          pend_name = name;
          pend_levels = exp_lv;
          pend_valid = 1'b1;
        end else begin
          idle_bits(2);
          compare_value(name, exp_lv, byte_t'(btn_levels));
          // gap of 2 to 5 bit periods in total
          extra = $random(seed) & 3;
          if (extra > 0) begin
            idle_bits(extra);
          end
        end
      end
      $fclose(fd);
    end
    if (pend_valid) begin
      idle_bits(2);
      compare_value(pend_name, pend_levels, byte_t'(btn_levels));
    end
    wait_cnt = 0;
    while (echo_seen.size() < echo_expected.size() && wait_cnt < 20 * clks_per_bit) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (echo_seen.size() < echo_expected.size()) begin
      $display("echo timed out, %0d of %0d bytes came back",
               echo_seen.size(), echo_expected.size());
      other_errors++;
    end
    // room for a stray extra frame
    idle_bits(12);
    compare_value("echo count", byte_t'(echo_expected.size()), byte_t'(echo_seen.size()));
    for (int i = 0; i < echo_expected.size() && i < echo_seen.size(); i++) begin
      compare_value($sformatf("echo %0d", i), echo_expected[i], echo_seen[i]);
    end
    tb_done = 1'b1;
    $display("errors: %0d failed checks, %0d other", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb/cmd_trace.txt */
# columns are action, byte in hex, btn_levels afterwards in hex, echo flag
# a burst frame runs straight into the frame of the next line
send   31 01 1
send   32 03 1
send   33 07 1
send   34 0f 1
send   35 1f 1
send   30 00 1
send   33 04 1
send   41 00 1
glitch 00 00 0
send   35 10 1
burst  31 11 1
send   32 13 0
glitch 00 13 0
send   30 00 1
send   32 02 1
burst  7a 00 1
send   34 08 0
send   34 08 1

/* project.f */
hw/bt_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/btn_cmd_decoder.sv
hw/fan_bluetooth_top.sv
tb/tb_fan_bluetooth.sv

/* Makefile */
SIM = obj_dir/Vtb_fan_bluetooth

$(SIM): project.f $(wildcard hw/*.sv tb/*.sv)
	verilator --binary --timing --top-module tb_fan_bluetooth -f project.f -o Vtb_fan_bluetooth

run: $(SIM)
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
